// ==== mems_scan.f ====
+incdir+source
source/mems_scan_pkg.sv
source/mems_spi_master.sv
source/mems_dac_cmd_rom.sv
source/mems_raster_gen.sv
source/mems_scan_sequencer.sv
source/mems_scan_top.sv
sim/mems_scan_tb.sv

// ==== Makefile ====
TOP := mems_scan_tb

all: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

build:
	verilator --binary --timing -f mems_scan.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only --timing -f mems_scan.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build lint clean

// ==== sim/mems_scan_tb.sv ====
`timescale 1ns/1ps

module mems_scan_tb;

  import mems_scan_pkg::*;

  // small raster so line and frame wraps come quickly
  localparam logic [7:0] fast_low  = 8'd34;
  localparam logic [7:0] fast_high = 8'd37;
  localparam logic [7:0] slow_low  = 8'd34;
  localparam logic [7:0] slow_high = 8'd38;
  localparam logic [7:0] slow_step = 8'd2;

  localparam logic [2:0] op_write = 3'b011;
  localparam logic [2:0] op_reset = 3'b101;
  localparam logic [2:0] op_ldac  = 3'b110;
  localparam logic [2:0] op_ref   = 3'b111;

  localparam int ev_none  = 0;
  localparam int ev_line  = 1;
  localparam int ev_frame = 2;
  localparam int word_timeout = 1000;   // one word is about 100 clk

  logic        clk;
  logic        mems_soft_reset;
  logic        pause;
  logic        new_line_done;
  logic        new_frame_done;
  spi_pins_t   spi;
  logic        new_line;
  logic        new_frame;

  logic [23:0] words[$];   // decoded SPI words
  logic [23:0] shift_in;
  logic        last_sclk = 1'b1;
  int          bit_cnt = 0;
  scan_codes_t model;
  int          seed;
  int          error_count = 0;
  int          check_count = 0;
  int          line_count = 0;
  int          frame_count = 0;
  int          last_event;
  bit          auto_ack = 1'b1;

  mems_scan_top #(
    .fast_low  (fast_low),
    .fast_high (fast_high),
    .slow_low  (slow_low),
    .slow_high (slow_high),
    .slow_step (slow_step)
  ) u_mems_scan_top (
    .clk             (clk),
    .mems_soft_reset (mems_soft_reset),
    .pause           (pause),
    .new_line_done   (new_line_done),
    .new_frame_done  (new_frame_done),
    .spi             (spi),
    .new_line        (new_line),
    .new_frame       (new_frame)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // word decoder, DAC samples mosi on falling SCLK
  always @(negedge clk) begin
    if (mems_soft_reset || spi.sync_n) begin
      bit_cnt = 0;
    end else if (last_sclk && !spi.sclk) begin
      shift_in = {shift_in[22:0], spi.mosi};
      bit_cnt++;
      if (bit_cnt == 24) begin
        words.push_back(shift_in);
        bit_cnt = 0;
      end
    end
    last_sclk = spi.sclk;
  end

  function automatic logic [23:0] expected_word(input logic [2:0] op, input logic [2:0] ch,
                                                input logic [15:0] data);
    return {2'b00, op, ch, data};
  endfunction

  function automatic void reset_model();
    model.a = fast_low;
    model.b = fast_high;
    model.c = slow_low;
    model.d = slow_high;
  endfunction

  // raster rule, one call per refresh group
  function automatic int step_model();
    int ev;
    ev = ev_none;
    if (model.a > fast_high) begin
      model.a = fast_low;
      model.b = fast_high;
      if (model.c > slow_high) begin
        model.c = slow_low;
        model.d = slow_high;
        ev = ev_frame;
      end else begin
        model.c = model.c + slow_step;
        model.d = model.d - slow_step;
        ev = ev_line;
      end
    end else begin
      model.a = model.a + 8'd1;
      model.b = model.b - 8'd1;
    end
    return ev;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic abort_run(input string why);
    $display("Timeout at %0t ns: %s", $time, why);
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    $display("Simulation FAILED");
    $finish;
  endtask

  task automatic wait_word(output logic [23:0] w);
    int n;
    n = 0;
    while (words.size() == 0 && n < word_timeout) begin
      @(posedge clk);
      n++;
    end
    if (words.size() == 0) abort_run("no SPI word arrived from the DUT");
    else w = words.pop_front();
  endtask

  task automatic expect_word(input logic [23:0] exp, input string what);
    logic [23:0] w;
    wait_word(w);
    check_value(32'(w), 32'(exp), what);
  endtask

  // holds reset, pins must idle and flags stay low
  task automatic apply_reset();
    @(negedge clk);
    mems_soft_reset = 1'b1;
    repeat (10) begin
      @(negedge clk);
      check_value(32'(spi.sync_n), 32'd1, "sync_n in reset");
      check_value(32'(spi.sclk), 32'd1, "sclk in reset");
      check_value(32'(spi.mosi), 32'd0, "mosi in reset");
      check_value(32'(new_line), 32'd0, "new_line in reset");
      check_value(32'(new_frame), 32'd0, "new_frame in reset");
    end
    words.delete();
    reset_model();
    mems_soft_reset = 1'b0;
  endtask

  task automatic check_setup();
    expect_word(expected_word(op_reset, 3'd0, 16'h0001), "software reset word");
    expect_word(expected_word(op_ldac, 3'd0, 16'h000F), "LDAC setup word");
  endtask

  task automatic ack_flag(input int ev);
    int delay;
    delay = 1 + ($random(seed) & 15);
    repeat (delay) @(negedge clk);
    if (ev == ev_line) begin
      check_value(32'(new_line), 32'd1, "new_line held before done");
      new_line_done = 1'b1;
    end else begin
      check_value(32'(new_frame), 32'd1, "new_frame held before done");
      new_frame_done = 1'b1;
    end
    @(negedge clk);
    new_line_done  = 1'b0;
    new_frame_done = 1'b0;
    check_value(32'(new_line), 32'd0, "new_line after done");
    check_value(32'(new_frame), 32'd0, "new_frame after done");
  endtask

  // one refresh group: A, B, C, D, internal reference
  task automatic check_group(input bit hold_after_b);
    int ev;
    ev = step_model();
    last_event = ev;
    expect_word(expected_word(op_write, 3'd0, {model.a, 8'h00}), "write A word");
    @(negedge clk);
    if (new_line === 1'b1) line_count++;   // flags as the DUT raised them
    if (new_frame === 1'b1) frame_count++;
    check_value(32'(new_line), (ev == ev_line) ? 32'd1 : 32'd0, "new_line after A word");
    check_value(32'(new_frame), (ev == ev_frame) ? 32'd1 : 32'd0, "new_frame after A word");
    if (ev != ev_none && auto_ack) ack_flag(ev);
    expect_word(expected_word(op_write, 3'd1, {model.b, 8'h00}), "write B word");
    if (hold_after_b) begin
      @(negedge clk);
      pause = 1'b1;
    end
    expect_word(expected_word(op_write, 3'd2, {model.c, 8'h00}), "write C word");
    expect_word(expected_word(op_write, 3'd3, {model.d, 8'h00}), "write D word");
    expect_word(expected_word(op_ref, 3'd0, 16'h0001), "internal reference word");
  endtask

  task automatic test_reset_state();
    apply_reset();
    check_setup();
  endtask

  // 22 groups cover three lines and one frame wrap
  task automatic test_refresh_flags();
    repeat (22) check_group(1'b0);
    check_value(32'(line_count), 32'd3, "line wraps seen");
    check_value(32'(frame_count), 32'd1, "frame wraps seen");
  endtask

  task automatic test_pause();
    int n;
    int low_seen;
    check_group(1'b1);
    n = 0;
    while (spi.sync_n !== 1'b1 && n < 200) begin
      @(negedge clk);
      n++;
    end
    if (spi.sync_n !== 1'b1) abort_run("sync_n stayed low after the paused group");
    low_seen = 0;
    repeat (400) begin
      @(negedge clk);
      if (spi.sync_n !== 1'b1) low_seen++;
    end
    check_value(32'(low_seen), 32'd0, "sync_n low cycles while paused");
    check_value(32'(words.size()), 32'd0, "words sent while paused");
    pause = 1'b0;
    repeat (3) check_group(1'b0);   // no code skipped after release
  endtask

  task automatic test_midrun_reset();
    int n;
    auto_ack   = 1'b0;
    last_event = ev_none;
    n = 0;
    while (last_event == ev_none && n < 10) begin
      check_group(1'b0);
      n++;
    end
    @(negedge clk);
    check_value(32'(new_line | new_frame), 32'd1, "flag pending before reset");
    apply_reset();
    auto_ack = 1'b1;
    check_setup();
    repeat (6) check_group(1'b0);
  endtask

  initial begin
    seed            = 80946;
    mems_soft_reset = 1'b1;
    pause           = 1'b0;
    new_line_done   = 1'b0;
    new_frame_done  = 1'b0;
    reset_model();

    test_reset_state();
    test_refresh_flags();
    test_pause();
    test_midrun_reset();

    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== source/mems_scan_top.sv ====
`timescale 1ns/1ps
`include "mems_scan_params.svh"

module mems_scan_top #(
  parameter mems_scan_pkg::dac_code_t fast_low  = `MEMS_FAST_LOW,
  parameter mems_scan_pkg::dac_code_t fast_high = `MEMS_FAST_HIGH,
  parameter mems_scan_pkg::dac_code_t slow_low  = `MEMS_SLOW_LOW,
  parameter mems_scan_pkg::dac_code_t slow_high = `MEMS_SLOW_HIGH,
  parameter mems_scan_pkg::dac_code_t slow_step = `MEMS_SLOW_STEP
) (
  input  logic                     clk,
  input  logic                     mems_soft_reset,
  input  logic                     pause,
  input  logic                     new_line_done,
  input  logic                     new_frame_done,
  output mems_scan_pkg::spi_pins_t spi,
  output logic                     new_line,
  output logic                     new_frame
);

  import mems_scan_pkg::*;

  cmd_addr_t   cmd_addr;
  scan_codes_t codes;
  spi_word_t   word;
  logic        spi_start;
  logic        advance;
  logic        busy;

  mems_scan_sequencer u_mems_scan_sequencer (
    .clk             (clk),
    .mems_soft_reset (mems_soft_reset),
    .pause           (pause),
    .busy            (busy),
    .cmd_addr        (cmd_addr),
    .spi_start       (spi_start),
    .advance         (advance)
  );

  mems_raster_gen #(
    .fast_low  (fast_low),
    .fast_high (fast_high),
    .slow_low  (slow_low),
    .slow_high (slow_high),
    .slow_step (slow_step)
  ) u_mems_raster_gen (
    .clk             (clk),
    .mems_soft_reset (mems_soft_reset),
    .advance         (advance),
    .new_line_done   (new_line_done),
    .new_frame_done  (new_frame_done),
    .codes           (codes),
    .new_line        (new_line),
    .new_frame       (new_frame)
  );

  mems_dac_cmd_rom u_mems_dac_cmd_rom (
    .clk   (clk),
    .addr  (cmd_addr),
    .codes (codes),
    .word  (word)
  );

  mems_spi_master u_mems_spi_master (
    .clk             (clk),
    .mems_soft_reset (mems_soft_reset),
    .start           (spi_start),
    .word            (word),
    .busy            (busy),
    .spi             (spi)
  );

endmodule

// ==== source/mems_scan_sequencer.sv ====
`timescale 1ns/1ps

module mems_scan_sequencer (
  input  logic                     clk,
  input  logic                     mems_soft_reset,
  input  logic                     pause,
  input  logic                     busy,
  output mems_scan_pkg::cmd_addr_t cmd_addr,
  output logic                     spi_start,
  output logic                     advance
);

  import mems_scan_pkg::*;

  seq_state_t seq_state;
  seq_state_t seq_next;
  ch_state_t  ch_state;
  ch_state_t  ch_next;
  cmd_addr_t  addr_next;
  logic       pending;     // index set, start goes out next cycle
  logic       link_free;
  logic       issue;

  // no word in flight and none queued
  assign link_free = !busy && !pending && !spi_start;

  always_comb begin
    seq_next  = seq_state;
    ch_next   = ch_state;
    addr_next = cmd_addr;
    issue     = 1'b0;
    advance   = 1'b0;

    if (link_free) begin
      case (seq_state)
        st_setup_reset: begin
          issue     = 1'b1;
          addr_next = cmd_sw_reset;
          seq_next  = st_setup_ldac;
        end

        st_setup_ldac: begin
          issue     = 1'b1;
          addr_next = cmd_ldac;
          seq_next  = st_refresh;
          ch_next   = ch_a;
        end

        st_refresh: begin
          case (ch_state)
            ch_a: begin
              // top of refresh cycle, pause holds here
              if (!pause) begin
                issue     = 1'b1;
                advance   = 1'b1;   // codes settle before ROM registers
                addr_next = cmd_wr_a;
                ch_next   = ch_b;
              end
            end

            ch_b: begin
              issue     = 1'b1;
              addr_next = cmd_wr_b;
              ch_next   = ch_c;
            end

            ch_c: begin
              issue     = 1'b1;
              addr_next = cmd_wr_c;
              ch_next   = ch_d;
            end

            ch_d: begin
              issue     = 1'b1;
              addr_next = cmd_wr_d;
              ch_next   = ch_ref;
            end

            ch_ref: begin
              issue     = 1'b1;
              addr_next = cmd_int_ref;
              ch_next   = ch_a;
            end

            default: ch_next = ch_a;
          endcase
        end

        default: seq_next = st_setup_reset;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      seq_state <= st_setup_reset;   // setup words repeat after release
      ch_state  <= ch_a;
      cmd_addr  <= cmd_sw_reset;
      pending   <= 1'b0;
      spi_start <= 1'b0;
    end else begin
      seq_state <= seq_next;
      ch_state  <= ch_next;
      cmd_addr  <= addr_next;
      pending   <= issue;
      spi_start <= pending;   // one cycle behind index for ROM latency
    end
  end

endmodule

// ==== source/mems_raster_gen.sv ====
`timescale 1ns/1ps
`include "mems_scan_params.svh"

module mems_raster_gen #(
  parameter mems_scan_pkg::dac_code_t fast_low  = `MEMS_FAST_LOW,
  parameter mems_scan_pkg::dac_code_t fast_high = `MEMS_FAST_HIGH,
  parameter mems_scan_pkg::dac_code_t slow_low  = `MEMS_SLOW_LOW,
  parameter mems_scan_pkg::dac_code_t slow_high = `MEMS_SLOW_HIGH,
  parameter mems_scan_pkg::dac_code_t slow_step = `MEMS_SLOW_STEP
) (
  input  logic                       clk,
  input  logic                       mems_soft_reset,
  input  logic                       advance,
  input  logic                       new_line_done,
  input  logic                       new_frame_done,
  output mems_scan_pkg::scan_codes_t codes,
  output logic                       new_line,
  output logic                       new_frame
);

  logic line_end;    // fast axis wraps on this advance
  logic frame_end;   // slow axis wraps too

  assign line_end  = advance && (codes.a > fast_high);
  assign frame_end = line_end && (codes.c > slow_high);

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      codes.a <= fast_low;
      codes.b <= fast_high;
      codes.c <= slow_low;
      codes.d <= slow_high;
    end else if (frame_end) begin
      codes.a <= fast_low;
      codes.b <= fast_high;
      codes.c <= slow_low;
      codes.d <= slow_high;
    end else if (line_end) begin
      codes.a <= fast_low;
      codes.b <= fast_high;
      codes.c <= codes.c + slow_step;
      codes.d <= codes.d - slow_step;
    end else if (advance) begin
      codes.a <= codes.a + 8'd1;   // complementary sawtooth
      codes.b <= codes.b - 8'd1;
    end
  end

  // flags held until the capture side acknowledges
  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      new_line  <= 1'b0;
      new_frame <= 1'b0;
    end else begin
      if (line_end && !frame_end) begin
        new_line <= 1'b1;   // a new event wins over done
      end else if (new_line_done) begin
        new_line <= 1'b0;
      end

      if (frame_end) begin
        new_frame <= 1'b1;
      end else if (new_frame_done) begin
        new_frame <= 1'b0;
      end
    end
  end

endmodule

// ==== source/mems_dac_cmd_rom.sv ====
`timescale 1ns/1ps

module mems_dac_cmd_rom (
  input  logic                       clk,
  input  mems_scan_pkg::cmd_addr_t   addr,
  input  mems_scan_pkg::scan_codes_t codes,
  output mems_scan_pkg::spi_word_t   word
);

  import mems_scan_pkg::*;

  // DAC command field values
  localparam logic [2:0] op_write_upd = 3'b011;
  localparam logic [2:0] op_sw_reset  = 3'b101;
  localparam logic [2:0] op_ldac      = 3'b110;
  localparam logic [2:0] op_int_ref   = 3'b111;

  function automatic spi_word_t pack_word(
    input logic [2:0]  op,
    input logic [2:0]  ch,
    input logic [15:0] data
  );
    return {2'b00, op, ch, data};
  endfunction

  // code goes in the upper data byte
  function automatic spi_word_t write_word(
    input logic [2:0] ch,
    input dac_code_t  code
  );
    return pack_word(op_write_upd, ch, {code, 8'h00});
  endfunction

  always_ff @(posedge clk) begin
    case (addr)
      cmd_sw_reset: word <= pack_word(op_sw_reset, 3'd0, 16'h0001);
      cmd_ldac:     word <= pack_word(op_ldac, 3'd0, 16'h000F);   // LDAC on all channels
      cmd_int_ref:  word <= pack_word(op_int_ref, 3'd0, 16'h0001);
      cmd_wr_a:     word <= write_word(3'd0, codes.a);
      cmd_wr_b:     word <= write_word(3'd1, codes.b);
      cmd_wr_c:     word <= write_word(3'd2, codes.c);
      cmd_wr_d:     word <= write_word(3'd3, codes.d);
      default:      word <= '0;   // unused index
    endcase
  end

endmodule

// ==== source/mems_spi_master.sv ====
`timescale 1ns/1ps
`include "mems_scan_params.svh"

module mems_spi_master (
  input  logic                     clk,
  input  logic                     mems_soft_reset,
  input  logic                     start,
  input  mems_scan_pkg::spi_word_t word,
  output logic                     busy,
  output mems_scan_pkg::spi_pins_t spi
);

  import mems_scan_pkg::*;

  localparam int div_w = $clog2(`MEMS_SCLK_HALF + 1);
  localparam logic [div_w-1:0] div_last = div_w'(`MEMS_SCLK_HALF - 1);
  localparam logic [5:0] half_last = 6'd47;   // 24 falls + 24 rises

  logic [div_w-1:0] div_cnt;
  logic [5:0]       half_cnt;   // SCLK half periods done in this frame
  spi_word_t        shreg;
  logic             half_tick;
  logic             launch;

  assign launch    = start && !busy;
  assign half_tick = busy && (div_cnt == div_last);

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      busy       <= 1'b0;
      spi.sclk   <= 1'b1;
      spi.sync_n <= 1'b1;
      spi.mosi   <= 1'b0;
      div_cnt    <= '0;
      half_cnt   <= '0;
    end else if (launch) begin
      busy       <= 1'b1;
      spi.sync_n <= 1'b0;
      spi.mosi   <= word[23];   // MSB ready before first falling edge
      div_cnt    <= '0;
      half_cnt   <= '0;
    end else if (half_tick) begin
      div_cnt  <= '0;
      half_cnt <= half_cnt + 6'd1;
      spi.sclk <= ~spi.sclk;
      if (half_cnt == half_last) begin
        // last rising edge closes the frame
        busy       <= 1'b0;
        spi.sync_n <= 1'b1;
        spi.mosi   <= 1'b0;
      end else if (!spi.sclk) begin
        spi.mosi <= shreg[22];   // next bit after rising edge
      end
    end else if (busy) begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // data path shift register
  always_ff @(posedge clk) begin
    if (launch) begin
      shreg <= word;
    end else if (half_tick && !spi.sclk) begin
      shreg <= {shreg[22:0], 1'b0};
    end
  end

endmodule

// ==== source/mems_scan_pkg.sv ====
package mems_scan_pkg;

  typedef logic [23:0] spi_word_t;   // {2'b00, cmd, addr, data}
  typedef logic [7:0]  dac_code_t;   // one channel code
  typedef logic [2:0]  cmd_addr_t;   // command table index

  // command table entries
  localparam cmd_addr_t cmd_sw_reset = 3'd0;
  localparam cmd_addr_t cmd_ldac     = 3'd1;
  localparam cmd_addr_t cmd_int_ref  = 3'd2;
  localparam cmd_addr_t cmd_wr_a     = 3'd3;
  localparam cmd_addr_t cmd_wr_b     = 3'd4;
  localparam cmd_addr_t cmd_wr_c     = 3'd5;
  localparam cmd_addr_t cmd_wr_d     = 3'd6;

  typedef struct packed {
    dac_code_t a;   // fast axis, rising
    dac_code_t b;   // fast axis, falling
    dac_code_t c;   // slow axis, rising
    dac_code_t d;   // slow axis, falling
  } scan_codes_t;

  typedef struct packed {
    logic sclk;
    logic sync_n;
    logic mosi;
  } spi_pins_t;

  typedef enum logic [1:0] {
    st_setup_reset,
    st_setup_ldac,
    st_refresh
  } seq_state_t;

  // next word of the refresh cycle
  typedef enum logic [2:0] {
    ch_a,
    ch_b,
    ch_c,
    ch_d,
    ch_ref
  } ch_state_t;

endpackage

// ==== source/mems_scan_params.svh ====
`ifndef MEMS_SCAN_PARAMS_SVH
`define MEMS_SCAN_PARAMS_SVH

// clk cycles per half SCLK period, sets the scan speed
`define MEMS_SCLK_HALF 2

// fast axis, channels A and B
`define MEMS_FAST_LOW  34
`define MEMS_FAST_HIGH 154

// slow axis, channels C and D
`define MEMS_SLOW_LOW  34
`define MEMS_SLOW_HIGH 154

// slow axis increment per fast line
`define MEMS_SLOW_STEP 2

`endif
